// ==== include/mem_defines.svh ====
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// Data word and byte address widths.
`define DATA_WIDTH 32
`define ADDR_WIDTH 32

// RAM depth is 2**RAM_ADDR_BITS bytes.
`define RAM_ADDR_BITS 10

// Request tag width.
`define NICK_WIDTH 4

// Length field, holds 1, 2 or 4.
`define LEN_WIDTH 3

`endif

// ==== source/memPkg.sv ====
`include "mem_defines.svh"

package memPkg;

    typedef logic [`DATA_WIDTH-1:0]    dataT;
    typedef logic [`ADDR_WIDTH-1:0]    addrT;
    typedef logic [`LEN_WIDTH-1:0]     lenT;
    typedef logic [`NICK_WIDTH-1:0]    nickT;
    typedef logic [7:0]                byteT;
    typedef logic [`RAM_ADDR_BITS-1:0] ramAddrT;

    // Memory controller sequencing.
    typedef enum logic [1:0] {
        CtrlIdle,
        CtrlAccess,
        CtrlFinish
    } ctrlStateT;

endpackage

// ==== source/dataPort.sv ====
`timescale 1ns/1ps

module dataPort
    import memPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic rdy,

    // Store/load buffer side.
    input  logic slbEn,
    input  logic slbLs,
    input  addrT slbAddr,
    input  dataT slbData,
    input  lenT  slbLen,
    input  nickT slbNick,
    output logic slbReady,
    output logic slbDone,
    output dataT slbResult,
    output nickT slbNickOut,

    // Memory controller side.
    input  logic mcBusy,
    input  logic mcDone,
    input  dataT mcResult,
    output logic mcEn,
    output logic mcLs,
    output addrT mcAddr,
    output dataT mcData,
    output lenT  mcLen
);

    logic occupied;
    logic issued;
    nickT reqNick;
    logic takeReq;

    // One entry only, so the buffer waits until the result is back.
    assign slbReady = rdy && !occupied;
    assign takeReq  = slbEn && slbReady;

    // ######################################################################
    // Entry control
    // ######################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= 1'b0;
            issued   <= 1'b0;
            mcEn     <= 1'b0;
            slbDone  <= 1'b0;
        end else if (rdy) begin
            mcEn    <= 1'b0;
            slbDone <= 1'b0;

            if (takeReq) begin
                occupied <= 1'b1;
                issued   <= 1'b0;
            end

            // Hand the held request to the controller exactly once.
            if (occupied && !issued && !mcBusy) begin
                mcEn   <= 1'b1;
                issued <= 1'b1;
            end

            if (mcDone) begin
                slbDone  <= 1'b1;
                occupied <= 1'b0;
            end
        end
    end

    // ######################################################################
    // Request and result payload
    // ######################################################################

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (takeReq) begin
                mcLs    <= slbLs;
                mcAddr  <= slbAddr;
                mcData  <= slbData;
                mcLen   <= slbLen;
                reqNick <= slbNick;
            end

            // Tag goes back with the data it belongs to.
            if (mcDone) begin
                slbResult  <= mcResult;
                slbNickOut <= reqNick;
            end
        end
    end

endmodule

// ==== source/memController.sv ====
`timescale 1ns/1ps

module memController
    import memPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    rdy,

    // Request from the data port.
    input  logic    mcEn,
    input  logic    mcLs,
    input  addrT    mcAddr,
    input  dataT    mcData,
    input  lenT     mcLen,
    output logic    mcBusy,
    output logic    mcDone,
    output dataT    mcResult,

    // Byte RAM port.
    input  byteT    ramRdata,
    output logic    ramWe,
    output ramAddrT ramAddr,
    output byteT    ramWdata
);

    ctrlStateT state;
    lenT       count;

    // Latched request.
    logic      reqLs;
    ramAddrT   reqBase;
    dataT      reqData;
    lenT       reqLen;
    dataT      acc;

    logic      lastStep;
    logic [1:0] prevLane;

    // Stores finish on the last byte, loads wait one more cycle for the
    // registered read of that byte.
    assign lastStep = reqLs ? (count == reqLen - 1'b1) : (count == reqLen);

    // Read data in this cycle belongs to the address of the previous one.
    assign prevLane = count[1:0] - 2'd1;

    assign mcBusy   = (state == CtrlAccess);
    assign mcDone   = (state == CtrlFinish);
    assign mcResult = acc;

    // ######################################################################
    // RAM drive
    // ######################################################################

    // While stalled, keep reading the byte the accumulator still waits for.
    assign ramAddr  = rdy ? reqBase + ramAddrT'(count)
                          : reqBase + ramAddrT'(count) - 1'b1;
    assign ramWdata = reqData[{count[1:0], 3'b000} +: 8];
    assign ramWe    = rdy && (state == CtrlAccess) && reqLs;

    // ######################################################################
    // Sequencer
    // ######################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CtrlIdle;
            count <= '0;
        end else if (rdy) begin
            unique case (state)
                CtrlIdle: begin
                    if (mcEn) begin
                        state <= CtrlAccess;
                        count <= '0;
                    end
                end
                CtrlAccess: begin
                    count <= count + 1'b1;
                    if (lastStep) begin
                        state <= CtrlFinish;
                    end
                end
                CtrlFinish: begin
                    state <= CtrlIdle;
                end
                default: begin
                    state <= CtrlIdle;
                end
            endcase
        end
    end

    // ######################################################################
    // Request latch and load assembly
    // ######################################################################

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (state == CtrlIdle && mcEn) begin
                reqLs   <= mcLs;
                reqBase <= ramAddrT'(mcAddr);
                reqData <= mcData;
                reqLen  <= mcLen;
                // Untouched lanes stay zero, which zero-extends short loads.
                acc     <= '0;
            end

            if (state == CtrlAccess && !reqLs && count != '0) begin
                acc[{prevLane, 3'b000} +: 8] <= ramRdata;
            end
        end
    end

endmodule

// ==== source/byteRam.sv ====
`timescale 1ns/1ps
`include "mem_defines.svh"

module byteRam
    import memPkg::*;
(
    input  logic    clk,
    input  logic    we,
    input  ramAddrT addr,
    input  byteT    wdata,
    output byteT    rdata
);

    byteT mem [0:(1 << `RAM_ADDR_BITS)-1];

    // Single port, read returns the old byte on a same-cycle write.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// ==== source/memSubsystem.sv ====
`timescale 1ns/1ps

module memSubsystem
    import memPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic rdy,

    input  logic slbEn,
    input  logic slbLs,
    input  addrT slbAddr,
    input  dataT slbData,
    input  lenT  slbLen,
    input  nickT slbNick,
    output logic slbReady,
    output logic slbDone,
    output dataT slbResult,
    output nickT slbNickOut
);

    // Data port to controller.
    logic    mcEn;
    logic    mcLs;
    addrT    mcAddr;
    dataT    mcData;
    lenT     mcLen;
    logic    mcBusy;
    logic    mcDone;
    dataT    mcResult;

    // Controller to RAM.
    logic    ramWe;
    ramAddrT ramAddr;
    byteT    ramWdata;
    byteT    ramRdata;

    dataPort i_dataPort (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .slbEn      (slbEn),
        .slbLs      (slbLs),
        .slbAddr    (slbAddr),
        .slbData    (slbData),
        .slbLen     (slbLen),
        .slbNick    (slbNick),
        .slbReady   (slbReady),
        .slbDone    (slbDone),
        .slbResult  (slbResult),
        .slbNickOut (slbNickOut),
        .mcBusy     (mcBusy),
        .mcDone     (mcDone),
        .mcResult   (mcResult),
        .mcEn       (mcEn),
        .mcLs       (mcLs),
        .mcAddr     (mcAddr),
        .mcData     (mcData),
        .mcLen      (mcLen)
    );

    memController i_memController (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .mcEn     (mcEn),
        .mcLs     (mcLs),
        .mcAddr   (mcAddr),
        .mcData   (mcData),
        .mcLen    (mcLen),
        .mcBusy   (mcBusy),
        .mcDone   (mcDone),
        .mcResult (mcResult),
        .ramRdata (ramRdata),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata)
    );

    byteRam i_byteRam (
        .clk   (clk),
        .we    (ramWe),
        .addr  (ramAddr),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

endmodule

// ==== dv/memSubsystemTb.sv ====
`timescale 1ns/1ps
`include "mem_defines.svh"

module memSubsystemTb
    import memPkg::*;
();

    localparam int RamBytes     = 1 << `RAM_ADDR_BITS;
    localparam int CyclesPerRow = 40;

    logic clk;
    logic rst;
    logic rdy;
    logic slbEn;
    logic slbLs;
    addrT slbAddr;
    dataT slbData;
    lenT  slbLen;
    nickT slbNick;
    logic slbReady;
    logic slbDone;
    dataT slbResult;
    nickT slbNickOut;

    // Stimulus table, one entry per request.
    string rowName  [$];
    logic  rowLs    [$];
    addrT  rowAddr  [$];
    dataT  rowData  [$];
    lenT   rowLen   [$];
    nickT  rowNick  [$];
    logic  rowStall [$];
    logic  rowDup   [$];

    // Reference copy of the RAM contents.
    byteT model [0:RamBytes-1];

    int rowErrors;
    int passCount;
    int failCount;
    int cycleCount;
    int cycleLimit;

    memSubsystem i_dut (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .slbEn      (slbEn),
        .slbLs      (slbLs),
        .slbAddr    (slbAddr),
        .slbData    (slbData),
        .slbLen     (slbLen),
        .slbNick    (slbNick),
        .slbReady   (slbReady),
        .slbDone    (slbDone),
        .slbResult  (slbResult),
        .slbNickOut (slbNickOut)
    );

    always #4 clk = ~clk;

    // Watchdog sized from the table length.
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, a request never completed.", cycleCount);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ######################################################################
    // Table, reference model and checks
    // ######################################################################

    task automatic addRow(input string name, input logic ls, input addrT addr,
                          input dataT data, input lenT len, input nickT nick,
                          input logic stall, input logic dup);
        rowName.push_back(name);
        rowLs.push_back(ls);
        rowAddr.push_back(addr);
        rowData.push_back(data);
        rowLen.push_back(len);
        rowNick.push_back(nick);
        rowStall.push_back(stall);
        rowDup.push_back(dup);
    endtask

    task automatic buildTable();
        dataT word;
        lenT  len;
        addrT base;
        addRow("store_word",      1, 32'h010, 32'h11223344, 3'd4, 4'h1, 0, 0);
        addRow("load_word",       0, 32'h010, 32'h0,        3'd4, 4'h2, 0, 0);
        addRow("load_byte",       0, 32'h011, 32'h0,        3'd1, 4'h3, 0, 0);
        addRow("load_half",       0, 32'h012, 32'h0,        3'd2, 4'h4, 0, 0);
        addRow("store_word_b",    1, 32'h020, 32'ha5b6c7d8, 3'd4, 4'h5, 0, 0);
        addRow("store_byte",      1, 32'h021, 32'hffffff5a, 3'd1, 4'h6, 0, 0);
        addRow("load_after_byte", 0, 32'h020, 32'h0,        3'd4, 4'h7, 0, 0);
        addRow("store_half",      1, 32'h022, 32'h1234beef, 3'd2, 4'h8, 0, 0);
        addRow("load_after_half", 0, 32'h020, 32'h0,        3'd4, 4'h9, 0, 0);
        addRow("load_top_byte",   0, 32'h023, 32'h0,        3'd1, 4'ha, 0, 0);
        addRow("store_extra_en",  1, 32'h030, 32'hcafef00d, 3'd4, 4'hb, 0, 1);
        addRow("load_extra_en",   0, 32'h030, 32'h0,        3'd4, 4'hc, 0, 0);
        addRow("store_stall",     1, 32'h040, 32'h01020304, 3'd4, 4'hd, 1, 0);
        addRow("load_stall",      0, 32'h040, 32'h0,        3'd4, 4'he, 1, 0);
        addRow("load_half_stall", 0, 32'h042, 32'h0,        3'd2, 4'hf, 1, 0);
        for (int i = 0; i < 8; i++) begin
            word = $urandom();
            base = 32'h100 + addrT'(4 * i);
            case ($urandom_range(0, 2))
                0: len = 3'd1;
                1: len = 3'd2;
                default: len = 3'd4;
            endcase
            addRow($sformatf("rand_store_%0d", i), 1, base, word, 3'd4,
                   nickT'($urandom()), 0, 0);
            addRow($sformatf("rand_load_%0d", i), 0,
                   base + addrT'($urandom_range(0, 4 - int'(len))), 32'h0, len,
                   nickT'($urandom()), $urandom_range(0, 1), 0);
        end
    endtask

    task automatic modelStore(input addrT addr, input dataT data, input lenT len);
        for (int k = 0; k < int'(len); k++) begin
            model[ramAddrT'(addr + addrT'(k))] = data[8*k +: 8];
        end
    endtask

    // Little-endian assembly, lanes past the length read as zero.
    function automatic dataT modelLoad(input addrT addr, input lenT len);
        dataT word;
        word = '0;
        for (int k = 0; k < int'(len); k++) begin
            word[8*k +: 8] = model[ramAddrT'(addr + addrT'(k))];
        end
        return word;
    endfunction

    task automatic noteFailure(input string msg);
        $display("%s", msg);
        rowErrors++;
    endtask

    task automatic checkData(input string name, input dataT expected, input dataT actual);
        if (actual !== expected) begin
            $display("ERR %s data expected %h actual %h", name, expected, actual);
            rowErrors++;
        end
    endtask

    task automatic checkNick(input string name, input nickT expected, input nickT actual);
        if (actual !== expected) begin
            $display("ERR %s tag expected %h actual %h", name, expected, actual);
            rowErrors++;
        end
    endtask

    task automatic finishTest(input string name);
        if (rowErrors == 0) begin
            $display("ok   %s", name);
            passCount++;
        end else begin
            $display("bad  %s (%0d errors)", name, rowErrors);
            failCount++;
        end
        rowErrors = 0;
    endtask

    // ######################################################################
    // Request driver
    // ######################################################################

    task automatic applyRow(input int i);
        dataT expected;
        int   cyc;
        int   stallLen;
        bit   finished;
        expected = rowLs[i] ? '0 : modelLoad(rowAddr[i], rowLen[i]);
        stallLen = $urandom_range(1, 3);
        do begin
            @(posedge clk);
            if (slbDone === 1'b1) begin
                noteFailure($sformatf("%s: slbDone pulsed with no request in flight",
                                      rowName[i]));
            end
        end while (slbReady !== 1'b1);
        slbEn   <= 1'b1;
        slbLs   <= rowLs[i];
        slbAddr <= rowAddr[i];
        slbData <= rowData[i];
        slbLen  <= rowLen[i];
        slbNick <= rowNick[i];
        @(posedge clk);
        if (slbReady !== 1'b1) begin
            noteFailure($sformatf("%s: the request was not accepted", rowName[i]));
        end
        // A second store raised while busy must be ignored.
        slbEn <= rowDup[i];
        if (rowDup[i]) begin
            slbLs   <= 1'b1;
            slbData <= ~rowData[i];
            slbNick <= ~rowNick[i];
        end
        cyc = 0;
        finished = 1'b0;
        while (!finished) begin
            @(posedge clk);
            cyc++;
            // Stall lands after the first byte, while its read data is still owed.
            if (rowStall[i] && cyc == 3) begin
                rdy <= 1'b0;
            end
            if (rowStall[i] && cyc == 3 + stallLen) begin
                rdy <= 1'b1;
            end
            if (rowDup[i] && cyc == 3) begin
                slbEn <= 1'b0;
            end
            if (slbDone === 1'b1) begin
                finished = 1'b1;
                if (rdy !== 1'b1) begin
                    noteFailure($sformatf("%s: slbDone high while rdy is low", rowName[i]));
                end
                checkData(rowName[i], expected, slbResult);
                checkNick(rowName[i], rowNick[i], slbNickOut);
            end else if (slbReady !== 1'b0) begin
                noteFailure($sformatf("%s: slbReady high before slbDone", rowName[i]));
            end
        end
        @(posedge clk);
        if (slbDone !== 1'b0) begin
            noteFailure($sformatf("%s: slbDone lasted more than one cycle", rowName[i]));
        end
        if (rowLs[i]) begin
            modelStore(rowAddr[i], rowData[i], rowLen[i]);
        end
        finishTest(rowName[i]);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        rdy        = 1'b1;
        slbEn      = 1'b0;
        slbLs      = 1'b0;
        slbAddr    = '0;
        slbData    = '0;
        slbLen     = '0;
        slbNick    = '0;
        rowErrors  = 0;
        passCount  = 0;
        failCount  = 0;
        cycleCount = 0;
        cycleLimit = 0;
        void'($urandom(32'hafcb3992));
        for (int a = 0; a < RamBytes; a++) begin
            model[a] = '0;
        end
        buildTable();
        cycleLimit = rowName.size() * CyclesPerRow;

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        repeat (3) begin
            @(posedge clk);
            if (slbReady !== 1'b1) begin
                noteFailure("reset: slbReady is not high after reset");
            end
            if (slbDone !== 1'b0) begin
                noteFailure("reset: slbDone is high with no request");
            end
        end
        finishTest("reset");

        for (int i = 0; i < rowName.size(); i++) begin
            applyRow(i);
        end

        // Nothing may complete once the table is drained.
        repeat (10) begin
            @(posedge clk);
            if (slbDone !== 1'b0) begin
                noteFailure("idle_tail: slbDone pulsed after the last request");
            end
        end
        finishTest("idle_tail");

        $display("Tests: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
source/memPkg.sv
source/dataPort.sv
source/memController.sv
source/byteRam.sv
source/memSubsystem.sv
dv/memSubsystemTb.sv
